// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_mac_tx
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: common/mac_tx_config.svh
`ifndef MAC_TX_CONFIG_SVH
`define MAC_TX_CONFIG_SVH

// frame layout
`define MAC_LEN_W          11
`define MAC_MIN_PAYLOAD    60
`define MAC_PREAMBLE_LEN   7
`define MAC_PREAMBLE_BYTE  8'h55
`define MAC_SFD            8'hD5
`define MAC_CRC_LEN        4
`define MAC_OVERHEAD       12      // preamble + sfd + fcs
`define MAC_IFG            12      // idle cycles between frames

// staging fifos
`define MAC_STAGE_DEPTH    4096
`define MAC_STAGE_AFULL    (4096 - 1518 - 8)   // room for one max frame + header
`define MAC_LDESC_DEPTH    32

`endif

// File: common/mac_tx_pkg.sv
`include "mac_tx_config.svh"

package mac_tx_pkg;

    // upstream queue descriptor, one per frame
    typedef struct packed {
        logic [15-`MAC_LEN_W:0] rsvd;
        logic [`MAC_LEN_W-1:0]  len;      // payload bytes
    } queue_desc_t;

    // handed from builder to sender once the frame is staged
    typedef struct packed {
        logic                  gmii;     // 1: byte per cycle, 0: nibbles
        logic [`MAC_LEN_W-1:0] wire_len; // bytes on the wire incl. preamble and fcs
    } line_desc_t;

    typedef enum logic [2:0] {
        BLD_IDLE,
        BLD_START,
        BLD_PREAMBLE,
        BLD_PREFETCH,
        BLD_DATA,
        BLD_PAD,
        BLD_CRC,
        BLD_COMMIT
    } builder_state_e;

    typedef enum logic [2:0] {
        SND_IDLE,
        SND_FETCH,
        SND_LOAD,
        SND_LO_NIBBLE,
        SND_HI_NIBBLE,
        SND_BYTE,
        SND_GAP
    } sender_state_e;

endpackage

// File: common/stage_if.sv
`timescale 1ns/100ps

// fifo link, rdata valid the cycle after rd
interface stage_if #(
    parameter type T           = logic [7:0],
    parameter int  DEPTH       = 16,
    parameter int  AFULL_LEVEL = DEPTH - 1
);

    logic wr;
    T     wdata;
    logic full;
    logic almost_full;

    logic rd;
    T     rdata;
    logic empty;

    modport writer  (output wr, output wdata, input full, input almost_full);
    modport reader  (output rd, input rdata, input empty);

    // fifo side of the link
    modport fifo_wr (input wr, input wdata, output full, output almost_full);
    modport fifo_rd (input rd, output rdata, output empty);

endinterface

// File: frame_builder/frame_builder.sv
`timescale 1ns/100ps
`include "mac_tx_config.svh"

module frame_builder import mac_tx_pkg::*; (
    input  logic        tx_master_clk,
    input  logic        rstn_mac,
    input  logic        gmii_mode,
    // normal queue
    output logic        ptr_fifo_rd,
    input  queue_desc_t ptr_fifo_din,
    input  logic        ptr_fifo_empty,
    output logic        data_fifo_rd,
    input  logic [7:0]  data_fifo_din,
    // tte queue
    output logic        tptr_fifo_rd,
    input  queue_desc_t tptr_fifo_din,
    input  logic        tptr_fifo_empty,
    output logic        tdata_fifo_rd,
    input  logic [7:0]  tdata_fifo_din,
    // staging
    stage_if.writer     byte_link,
    stage_if.writer     desc_link
);

    localparam int            LW       = `MAC_LEN_W;
    localparam logic [LW-1:0] MIN_PAY  = `MAC_MIN_PAYLOAD;
    localparam logic [LW-1:0] PRE_LAST = `MAC_PREAMBLE_LEN - 1;
    localparam logic [LW-1:0] CRC_LEN  = `MAC_CRC_LEN;
    localparam logic [LW-1:0] OVERHEAD = `MAC_OVERHEAD;

    builder_state_e state;
    builder_state_e state_next;

    logic [LW-1:0]  cnt;        // bytes left in the current phase
    logic [LW-1:0]  len_q;
    logic [LW-1:0]  pad_len;
    logic [LW-1:0]  padded;
    logic           sel_tte;
    logic           mode_q;
    logic           start_ok;
    logic           data_rd;
    queue_desc_t    q_desc;
    logic [7:0]     q_byte;

    logic           crc_init;
    logic           crc_update;
    logic [7:0]     crc_data;
    logic           crc_shift;
    logic [7:0]     fcs_byte;

    //////////////////////////////////////////////////
    // queue select and upstream reads
    //////////////////////////////////////////////////

    assign q_desc  = sel_tte ? tptr_fifo_din : ptr_fifo_din;
    assign q_byte  = sel_tte ? tdata_fifo_din : data_fifo_din;

    assign pad_len = (len_q < MIN_PAY) ? MIN_PAY - len_q : '0;
    assign padded  = len_q + pad_len;

    // a commit still in flight is not yet seen in the desc fifo level
    assign start_ok = (!tptr_fifo_empty || !ptr_fifo_empty) && !byte_link.almost_full &&
                      !desc_link.full && !desc_link.wr;

    assign tptr_fifo_rd  = (state == BLD_START) && sel_tte;
    assign ptr_fifo_rd   = (state == BLD_START) && !sel_tte;

    // one read ahead of each payload byte written
    assign data_rd = ((state == BLD_PREFETCH) && (len_q != '0)) ||
                     ((state == BLD_DATA) && (cnt > pad_len + 1'b1));
    assign tdata_fifo_rd = data_rd && sel_tte;
    assign data_fifo_rd  = data_rd && !sel_tte;

    //////////////////////////////////////////////////
    // fsm
    //////////////////////////////////////////////////

    always_comb begin
        state_next = state;
        case (state)
            BLD_IDLE:     if (start_ok) state_next = BLD_START;
            BLD_START:    state_next = BLD_PREAMBLE;
            BLD_PREAMBLE: if (cnt == 'd1) state_next = BLD_PREFETCH;
            BLD_PREFETCH: state_next = (len_q != '0) ? BLD_DATA : BLD_PAD;
            BLD_DATA: begin
                if (cnt == 'd1)
                    state_next = BLD_CRC;
                else if (cnt <= pad_len + 1'b1)
                    state_next = BLD_PAD;   // payload done, zero fill
            end
            BLD_PAD:      if (cnt == 'd1) state_next = BLD_CRC;
            BLD_CRC:      if (cnt == 'd1) state_next = BLD_COMMIT;
            BLD_COMMIT:   state_next = BLD_IDLE;
            default:      state_next = BLD_IDLE;
        endcase
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state   <= BLD_IDLE;
            cnt     <= '0;
            len_q   <= '0;
            sel_tte <= 1'b0;
            mode_q  <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                BLD_IDLE: begin
                    sel_tte <= !tptr_fifo_empty;   // strict tte priority
                    mode_q  <= gmii_mode;
                end
                BLD_START:    cnt <= PRE_LAST;
                BLD_PREAMBLE: begin
                    if (cnt == PRE_LAST) len_q <= q_desc.len;   // desc valid now
                    cnt <= cnt - 1'b1;
                end
                BLD_PREFETCH: cnt <= padded;
                BLD_DATA, BLD_PAD: cnt <= (cnt == 'd1) ? CRC_LEN : cnt - 1'b1;
                BLD_CRC:      cnt <= cnt - 1'b1;
                default:      cnt <= cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // staging writes
    //////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            byte_link.wr <= 1'b0;
            desc_link.wr <= 1'b0;
        end else begin
            byte_link.wr <= (state != BLD_IDLE) && (state != BLD_COMMIT);
            desc_link.wr <= (state == BLD_COMMIT);
        end
    end

    always_ff @(posedge tx_master_clk) begin
        case (state)
            BLD_START, BLD_PREAMBLE: byte_link.wdata <= `MAC_PREAMBLE_BYTE;
            BLD_PREFETCH:            byte_link.wdata <= `MAC_SFD;
            BLD_DATA:                byte_link.wdata <= q_byte;
            BLD_CRC:                 byte_link.wdata <= fcs_byte;
            default:                 byte_link.wdata <= 8'h00;   // pad
        endcase
        if (state == BLD_COMMIT) begin
            desc_link.wdata.gmii     <= mode_q;
            desc_link.wdata.wire_len <= padded + OVERHEAD;
        end
    end

    // fcs covers payload and pad only
    assign crc_init   = (state == BLD_START);
    assign crc_update = (state == BLD_DATA) || (state == BLD_PAD);
    assign crc_data   = (state == BLD_DATA) ? q_byte : 8'h00;
    assign crc_shift  = (state == BLD_CRC);

    crc32_8023 u_crc32_8023 (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .init          (crc_init),
        .update        (crc_update),
        .data          (crc_data),
        .shift_out     (crc_shift),
        .fcs_byte      (fcs_byte)
    );

endmodule

// File: line_sender/line_sender.sv
`timescale 1ns/100ps
`include "mac_tx_config.svh"

module line_sender import mac_tx_pkg::*; (
    input  logic       tx_master_clk,
    input  logic       rstn_mac,
    stage_if.reader    byte_link,
    stage_if.reader    desc_link,
    output logic       gtx_dv,
    output logic [7:0] gtx_d
);

    localparam int            LW       = `MAC_LEN_W;
    // the zero count plus idle and fetch give three more low cycles
    localparam logic [LW-1:0] GAP_LOAD = `MAC_IFG - 3;

    sender_state_e state;
    sender_state_e state_next;

    logic [LW-1:0] cnt;      // bytes after the current one and later the gap cycles
    logic          mode_q;   // 1: gmii
    logic          byte_rd;
    logic [7:0]    cur_byte;

    assign cur_byte    = byte_link.rdata;
    assign desc_link.rd = (state == SND_IDLE) && !desc_link.empty;
    assign byte_link.rd = byte_rd;

    // byte fetch runs one cycle ahead of the output register
    always_comb begin
        case (state)
            SND_FETCH:     byte_rd = 1'b1;
            SND_LOAD:      byte_rd = mode_q && (cnt != '0);
            SND_BYTE:      byte_rd = (cnt > 'd1);
            SND_HI_NIBBLE: byte_rd = (cnt != '0);
            default:       byte_rd = 1'b0;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            SND_IDLE:      if (!desc_link.empty) state_next = SND_FETCH;
            SND_FETCH:     state_next = SND_LOAD;
            SND_LOAD: begin
                if (!mode_q)
                    state_next = SND_HI_NIBBLE;
                else
                    state_next = (cnt == '0) ? SND_GAP : SND_BYTE;
            end
            SND_LO_NIBBLE: state_next = SND_HI_NIBBLE;
            SND_HI_NIBBLE: state_next = (cnt == '0) ? SND_GAP : SND_LO_NIBBLE;
            SND_BYTE:      if (cnt == 'd1) state_next = SND_GAP;
            SND_GAP:       if (cnt == '0) state_next = SND_IDLE;
            default:       state_next = SND_IDLE;
        endcase
    end

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            state  <= SND_IDLE;
            cnt    <= '0;
            mode_q <= 1'b0;
        end else begin
            state <= state_next;
            case (state)
                SND_FETCH: begin
                    mode_q <= desc_link.rdata.gmii;
                    cnt    <= desc_link.rdata.wire_len - 1'b1;
                end
                SND_LOAD:      if (mode_q && cnt == '0) cnt <= GAP_LOAD;
                SND_LO_NIBBLE: cnt <= cnt - 1'b1;
                SND_HI_NIBBLE: if (cnt == '0) cnt <= GAP_LOAD;
                SND_BYTE:      cnt <= (cnt == 'd1) ? GAP_LOAD : cnt - 1'b1;
                SND_GAP:       if (cnt != '0) cnt <= cnt - 1'b1;
                default:       cnt <= cnt;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // line outputs with the low nibble first in mii
    //////////////////////////////////////////////////

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            gtx_dv <= 1'b0;
            gtx_d  <= 8'h00;
        end else begin
            gtx_dv <= 1'b1;
            case (state)
                SND_LOAD:      gtx_d <= mode_q ? cur_byte : {4'h0, cur_byte[3:0]};
                SND_BYTE:      gtx_d <= cur_byte;
                SND_LO_NIBBLE: gtx_d <= {4'h0, cur_byte[3:0]};
                SND_HI_NIBBLE: gtx_d <= {4'h0, cur_byte[7:4]};
                default: begin
                    gtx_dv <= 1'b0;
                    gtx_d  <= 8'h00;
                end
            endcase
        end
    end

endmodule

// File: src/crc32_8023.sv
`timescale 1ns/100ps

module crc32_8023 (
    input  logic       tx_master_clk,
    input  logic       rstn_mac,
    input  logic       init,
    input  logic       update,
    input  logic [7:0] data,
    input  logic       shift_out,
    output logic [7:0] fcs_byte
);

    localparam logic [31:0] POLY_REFL = 32'hEDB8_8320;   // 0x04C11DB7 bit reversed

    logic [31:0] remainder;

    // lsb-first byte step, matches 802.3 bit order on the wire
    function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] c;
        c = crc ^ {24'h0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ POLY_REFL) : (c >> 1);
        end
        return c;
    endfunction

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            remainder <= '1;
        end else if (init) begin
            remainder <= '1;
        end else if (update) begin
            remainder <= crc_byte(remainder, data);
        end else if (shift_out) begin
            remainder <= {8'hFF, remainder[31:8]};   // next fcs byte down
        end
    end

    // inverted remainder, low byte goes out first
    assign fcs_byte = ~remainder[7:0];

endmodule

// File: src/mac_tx_top.sv
`timescale 1ns/100ps
`include "mac_tx_config.svh"

module mac_tx_top import mac_tx_pkg::*; (
    input  logic        tx_master_clk,
    input  logic        rstn_mac,
    input  logic        gmii_mode,     // sampled at each frame start
    // normal queue
    output logic        ptr_fifo_rd,
    input  logic [15:0] ptr_fifo_din,
    input  logic        ptr_fifo_empty,
    output logic        data_fifo_rd,
    input  logic [7:0]  data_fifo_din,
    // tte queue
    output logic        tptr_fifo_rd,
    input  logic [15:0] tptr_fifo_din,
    input  logic        tptr_fifo_empty,
    output logic        tdata_fifo_rd,
    input  logic [7:0]  tdata_fifo_din,
    // line
    output logic        gtx_dv,
    output logic [7:0]  gtx_d
);

    stage_if #(
        .T           (logic [7:0]),
        .DEPTH       (`MAC_STAGE_DEPTH),
        .AFULL_LEVEL (`MAC_STAGE_AFULL)
    ) byte_link ();

    stage_if #(
        .T           (line_desc_t),
        .DEPTH       (`MAC_LDESC_DEPTH),
        .AFULL_LEVEL (`MAC_LDESC_DEPTH)
    ) desc_link ();

    frame_builder u_frame_builder (
        .tx_master_clk   (tx_master_clk),
        .rstn_mac        (rstn_mac),
        .gmii_mode       (gmii_mode),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .data_fifo_rd    (data_fifo_rd),
        .data_fifo_din   (data_fifo_din),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_empty (tptr_fifo_empty),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .tdata_fifo_din  (tdata_fifo_din),
        .byte_link       (byte_link.writer),
        .desc_link       (desc_link.writer)
    );

    sync_fifo #(
        .T           (logic [7:0]),
        .DEPTH       (byte_link.DEPTH),
        .AFULL_LEVEL (byte_link.AFULL_LEVEL)
    ) u_byte_fifo (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .wr_side       (byte_link.fifo_wr),
        .rd_side       (byte_link.fifo_rd)
    );

    sync_fifo #(
        .T           (line_desc_t),
        .DEPTH       (desc_link.DEPTH),
        .AFULL_LEVEL (desc_link.AFULL_LEVEL)
    ) u_desc_fifo (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .wr_side       (desc_link.fifo_wr),
        .rd_side       (desc_link.fifo_rd)
    );

    line_sender u_line_sender (
        .tx_master_clk (tx_master_clk),
        .rstn_mac      (rstn_mac),
        .byte_link     (byte_link.reader),
        .desc_link     (desc_link.reader),
        .gtx_dv        (gtx_dv),
        .gtx_d         (gtx_d)
    );

endmodule

// File: src/sync_fifo.sv
`timescale 1ns/100ps

module sync_fifo #(
    parameter type T           = logic [7:0],
    parameter int  DEPTH       = 16,       // power of two
    parameter int  AFULL_LEVEL = DEPTH - 1
) (
    input  logic     tx_master_clk,
    input  logic     rstn_mac,
    stage_if.fifo_wr wr_side,
    stage_if.fifo_rd rd_side
);

    localparam int AW = $clog2(DEPTH);

    T               mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic [AW:0]    count;     // fill level
    logic           do_wr;
    logic           do_rd;

    assign do_wr = wr_side.wr && !wr_side.full;
    assign do_rd = rd_side.rd && !rd_side.empty;

    always_ff @(posedge tx_master_clk or negedge rstn_mac) begin
        if (!rstn_mac) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;   // wraps at DEPTH
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and registered read port
    always_ff @(posedge tx_master_clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_side.wdata;
        end
        if (do_rd) begin
            rd_side.rdata <= mem[rd_ptr];
        end
    end

    assign wr_side.full        = (count == (AW + 1)'(DEPTH));
    assign wr_side.almost_full = (count >= (AW + 1)'(AFULL_LEVEL));
    assign rd_side.empty       = (count == '0);

endmodule

// File: testbench/tb_mac_tx.sv
`timescale 1ns/100ps
`include "mac_tx_config.svh"

module tb_mac_tx;

    localparam int NUM_PHASES = 4;
    localparam int CLK_HALF   = 20;     // 40 ns period

    logic        tx_master_clk;
    logic        rstn_mac;
    logic        gmii_mode;
    logic        ptr_fifo_rd;
    logic [15:0] ptr_fifo_din;
    logic        ptr_fifo_empty;
    logic        data_fifo_rd;
    logic [7:0]  data_fifo_din;
    logic        tptr_fifo_rd;
    logic [15:0] tptr_fifo_din;
    logic        tptr_fifo_empty;
    logic        tdata_fifo_rd;
    logic [7:0]  tdata_fifo_din;
    logic        gtx_dv;
    logic [7:0]  gtx_d;

    // upstream queue models
    logic [15:0] nq_desc[$];
    logic [7:0]  nq_data[$];
    logic [15:0] tq_desc[$];
    logic [7:0]  tq_data[$];
    int          n_allow;               // payload bytes released by taken descriptors
    int          t_allow;
    logic        n_desc_pend;
    logic        n_data_pend;
    logic        t_desc_pend;
    logic        t_data_pend;
    logic [15:0] n_desc_val;
    logic [15:0] t_desc_val;
    logic [7:0]  n_data_val;
    logic [7:0]  t_data_val;

    // expected line traffic in wire order
    logic [7:0]  exp_bytes[$];
    int          exp_wire[$];
    logic        exp_mode[$];

    integer      seed;
    int          cycles;
    int          cycle_limit;
    int          frames_pushed;
    int          frames_done;
    int          len_list[$];
    int          tte_cnt[NUM_PHASES];
    int          norm_cnt[NUM_PHASES];
    logic        mode_tab[NUM_PHASES];

    // output checker state
    logic        in_frame;
    logic        cur_mode;
    int          cur_wire;
    int          cur_beats;
    int          beat;
    int          idle_cnt;
    logic [3:0]  lo_nib;

    mac_tx_top UUT (
        .tx_master_clk   (tx_master_clk),
        .rstn_mac        (rstn_mac),
        .gmii_mode       (gmii_mode),
        .ptr_fifo_rd     (ptr_fifo_rd),
        .ptr_fifo_din    (ptr_fifo_din),
        .ptr_fifo_empty  (ptr_fifo_empty),
        .data_fifo_rd    (data_fifo_rd),
        .data_fifo_din   (data_fifo_din),
        .tptr_fifo_rd    (tptr_fifo_rd),
        .tptr_fifo_din   (tptr_fifo_din),
        .tptr_fifo_empty (tptr_fifo_empty),
        .tdata_fifo_rd   (tdata_fifo_rd),
        .tdata_fifo_din  (tdata_fifo_din),
        .gtx_dv          (gtx_dv),
        .gtx_d           (gtx_d)
    );

    always #CLK_HALF tx_master_clk = ~tx_master_clk;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_mismatch(input string sig, input logic [7:0] want,
                                   input logic [7:0] got);
        report_failure($sformatf("Mismatch at %0d ns: %s expected 0x%h got 0x%h",
                                 $time, sig, want, got));
    endtask

    // bit-serial 802.3 remainder with data lsb first
    function automatic logic [31:0] crc_step(input logic [31:0] crc, input logic [7:0] d);
        logic [31:0] r;
        logic        fb;
        r = crc;
        for (int i = 0; i < 8; i++) begin
            fb = r[0] ^ d[i];
            r  = {1'b0, r[31:1]};
            if (fb)
                r = r ^ 32'hEDB8_8320;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////
    // stimulus and reference frames
    //////////////////////////////////////////////////

    task automatic push_frame(input logic tte, input int len, input logic mode);
        logic [31:0] crc;
        logic [7:0]  b;
        logic [15:0] desc;
        int          padded;
        crc    = 32'hFFFF_FFFF;
        padded = (len < `MAC_MIN_PAYLOAD) ? `MAC_MIN_PAYLOAD : len;
        desc   = {5'($random(seed)), 11'(len)};     // reserved bits are noise
        if (tte)
            tq_desc.push_back(desc);
        else
            nq_desc.push_back(desc);
        for (int i = 0; i < `MAC_PREAMBLE_LEN; i++) begin
            exp_bytes.push_back(`MAC_PREAMBLE_BYTE);
        end
        exp_bytes.push_back(`MAC_SFD);
        for (int i = 0; i < padded; i++) begin
            b = (i < len) ? 8'($random(seed)) : 8'h00;     // zero pad past len
            if (i < len && tte)
                tq_data.push_back(b);
            else if (i < len)
                nq_data.push_back(b);
            exp_bytes.push_back(b);
            crc = crc_step(crc, b);
        end
        crc = ~crc;
        for (int i = 0; i < `MAC_CRC_LEN; i++) begin
            exp_bytes.push_back(crc[8*i +: 8]);   // lsb first
        end
        exp_wire.push_back(padded + `MAC_OVERHEAD);
        exp_mode.push_back(mode);
        frames_pushed++;
    endtask

    task automatic update_empty();
        ptr_fifo_empty  = (nq_desc.size() == 0);
        tptr_fifo_empty = (tq_desc.size() == 0);
    endtask

    // one clock of the upstream queues with one cycle of read latency
    task automatic tick();
        @(negedge tx_master_clk);
        cycles++;
        if (cycles >= cycle_limit) begin
            report_failure($sformatf("timeout after %0d cycles, %0d of %0d frames seen",
                                     cycles, frames_done, frames_pushed));
        end
        if (!rstn_mac) begin
            assert (!gtx_dv && gtx_d == 8'h00 && !ptr_fifo_rd && !data_fifo_rd &&
                    !tptr_fifo_rd && !tdata_fifo_rd)
                else report_failure("gtx_dv, gtx_d or an upstream read is active during reset");
        end
        if (n_desc_pend) ptr_fifo_din   = n_desc_val;
        if (t_desc_pend) tptr_fifo_din  = t_desc_val;
        if (n_data_pend) data_fifo_din  = n_data_val;
        if (t_data_pend) tdata_fifo_din = t_data_val;
        n_desc_pend = ptr_fifo_rd;
        t_desc_pend = tptr_fifo_rd;
        n_data_pend = data_fifo_rd;
        t_data_pend = tdata_fifo_rd;
        if (ptr_fifo_rd) begin
            assert (nq_desc.size() > 0)
                else report_failure("ptr_fifo_rd raised with no normal descriptor waiting");
            n_desc_val = nq_desc.pop_front();
            n_allow   += int'(n_desc_val[10:0]);
        end
        if (tptr_fifo_rd) begin
            assert (tq_desc.size() > 0)
                else report_failure("tptr_fifo_rd raised with no TTE descriptor waiting");
            t_desc_val = tq_desc.pop_front();
            t_allow   += int'(t_desc_val[10:0]);
        end
        if (data_fifo_rd) begin
            assert (n_allow > 0 && nq_data.size() > 0)
                else report_failure("data_fifo_rd raised before a normal descriptor was taken");
            n_data_val = nq_data.pop_front();
            n_allow--;
        end
        if (tdata_fifo_rd) begin
            assert (t_allow > 0 && tq_data.size() > 0)
                else report_failure("tdata_fifo_rd raised before a TTE descriptor was taken");
            t_data_val = tq_data.pop_front();
            t_allow--;
        end
        update_empty();
    endtask

    //////////////////////////////////////////////////
    // line checker
    //////////////////////////////////////////////////

    task automatic check_byte(input logic [7:0] got, input int idx);
        logic [7:0] want;
        want = exp_bytes.pop_front();
        assert (got == want)
            else report_mismatch($sformatf("gtx_d (frame %0d byte %0d)", frames_done, idx),
                                 want, got);
    endtask

    always @(negedge tx_master_clk) begin
        if (rstn_mac && gtx_dv) begin
            if (!in_frame) begin
                assert (exp_wire.size() > 0)
                    else report_failure("gtx_dv rose with no frame expected");
                assert (frames_done == 0 || idle_cnt >= `MAC_IFG)
                    else report_failure($sformatf("gap of %0d cycles before frame %0d is too short",
                                                  idle_cnt, frames_done));
                in_frame  = 1'b1;
                cur_mode  = exp_mode.pop_front();
                cur_wire  = exp_wire.pop_front();
                cur_beats = cur_mode ? cur_wire : 2 * cur_wire;
                beat      = 0;
            end
            assert (beat < cur_beats)
                else report_failure($sformatf("gtx_dv held past %0d cycles in frame %0d",
                                              cur_beats, frames_done));
            if (cur_mode) begin
                check_byte(gtx_d, beat);
            end else begin
                assert (gtx_d[7:4] == 4'h0)
                    else report_mismatch("gtx_d[7:4]", 8'h00, {4'h0, gtx_d[7:4]});
                if (beat % 2 == 0)
                    lo_nib = gtx_d[3:0];     // low nibble first
                else
                    check_byte({gtx_d[3:0], lo_nib}, beat / 2);
            end
            beat++;
        end else if (rstn_mac) begin
            if (in_frame) begin
                assert (beat == cur_beats)
                    else report_failure($sformatf("frame %0d had gtx_dv high %0d cycles, not %0d",
                                                  frames_done, beat, cur_beats));
                in_frame = 1'b0;
                frames_done++;
                idle_cnt = 0;
            end
            idle_cnt++;
        end
    end

    initial begin
        logic [31:0] crc;
        string       check_str;
        int          total;
        int          f;
        seed            = 32'h7dfd_10ab;
        tx_master_clk   = 1'b0;
        rstn_mac        = 1'b0;
        gmii_mode       = 1'b1;
        ptr_fifo_din    = '0;
        tptr_fifo_din   = '0;
        data_fifo_din   = '0;
        tdata_fifo_din  = '0;
        ptr_fifo_empty  = 1'b1;
        tptr_fifo_empty = 1'b1;
        n_desc_pend     = 1'b0;
        n_data_pend     = 1'b0;
        t_desc_pend     = 1'b0;
        t_data_pend     = 1'b0;
        n_allow         = 0;
        t_allow         = 0;
        cycles          = 0;
        frames_pushed   = 0;
        frames_done     = 0;
        in_frame        = 1'b0;
        idle_cnt        = 0;
        beat            = 0;

        // known check value of the reference crc
        check_str = "123456789";
        crc       = 32'hFFFF_FFFF;
        for (int i = 0; i < check_str.len(); i++) begin
            crc = crc_step(crc, check_str[i]);
        end
        assert (~crc == 32'hCBF4_3926)
            else report_failure("reference CRC32 does not give the 802.3 check value");

        tte_cnt  = '{3, 1, 0, 2};
        norm_cnt = '{3, 2, 3, 1};
        mode_tab = '{1'b1, 1'b0, 1'b1, 1'b0};   // gmii mii gmii mii

        // even frames are long and odd frames need padding
        total       = 0;
        cycle_limit = 2000;
        for (int p = 0; p < NUM_PHASES; p++) begin
            total += tte_cnt[p] + norm_cnt[p];
        end
        for (int i = 0; i < total; i++) begin
            if (i % 2 == 0)
                f = 60 + int'($unsigned($random(seed)) % 241);
            else
                f = 1 + int'($unsigned($random(seed)) % 59);
            len_list.push_back(f);
            f = (f < `MAC_MIN_PAYLOAD) ? `MAC_MIN_PAYLOAD : f;
            cycle_limit += 2 * (f + `MAC_OVERHEAD + `MAC_IFG);
        end

        for (int p = 0; p < NUM_PHASES; p++) begin
            while (frames_done < frames_pushed) begin
                tick();
            end
            if (p > 0)
                repeat (20) tick();
            gmii_mode = mode_tab[p];
            // all loaded at once so tte frames leave first
            for (int i = 0; i < tte_cnt[p]; i++) begin
                push_frame(1'b1, len_list.pop_front(), mode_tab[p]);
            end
            for (int i = 0; i < norm_cnt[p]; i++) begin
                push_frame(1'b0, len_list.pop_front(), mode_tab[p]);
            end
            update_empty();
            if (p == 0) begin
                repeat (5) tick();
                rstn_mac = 1'b1;
            end
        end
        while (frames_done < frames_pushed) begin
            tick();
        end
        repeat (40) tick();       // nothing more may show up

        if (exp_bytes.size() == 0 && !in_frame && nq_data.size() == 0 &&
            tq_data.size() == 0 && n_allow == 0 && t_allow == 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_failure("frames or upstream bytes left over at the end of the run");
        end
    end

endmodule

// File: verilog.f
+incdir+common
common/mac_tx_pkg.sv
common/stage_if.sv
src/sync_fifo.sv
src/crc32_8023.sv
frame_builder/frame_builder.sv
line_sender/line_sender.sv
src/mac_tx_top.sv
testbench/tb_mac_tx.sv
